/* hdl/daq_chan_top.sv */
`timescale 1ns/1ps
module daq_chan_top
	import ring_pkg::*;
(
	input  logic        CLK,
	input  logic        RST_RESYNC,
	input  logic [11:0] adc_data,
	input  logic        adc_valid,
	input  logic [1:0]  trig_in,
	input  logic [6:0]  samp_max,
	input  logic        evt_buf_afl,
	input  logic        evt_buf_amt,
	output evt_hdr_t    evt_hdr,
	output logic        evt_push,
	output samp_word_t  rdata,
	output logic        data_push,
	output logic        warn
);

	samp_word_t samp;
	logic       wren;
	l1a_rec_t   l1a_rec;
	logic       l1a_push;
	logic       l1a_full;

	sample_frontend sample_frontend_i (
		.CLK        (CLK),
		.RST_RESYNC (RST_RESYNC),
		.adc_data   (adc_data),
		.adc_valid  (adc_valid),
		.trig_in    (trig_in),
		.samp_max   (samp_max),
		.l1a_full   (l1a_full),
		.samp       (samp),
		.wren       (wren),
		.l1a_rec    (l1a_rec),
		.l1a_push   (l1a_push)
	);

	ringbuf ringbuf_i (
		.CLK         (CLK),
		.RST_RESYNC  (RST_RESYNC),
		.samp        (samp),
		.wren        (wren),
		.l1a_rec     (l1a_rec),
		.l1a_push    (l1a_push),
		.samp_max    (samp_max),
		.evt_buf_afl (evt_buf_afl),
		.evt_buf_amt (evt_buf_amt),
		.l1a_full    (l1a_full),
		.evt_hdr     (evt_hdr),
		.evt_push    (evt_push),
		.rdata       (rdata),
		.data_push   (data_push),
		.warn        (warn)
	);

endmodule

/* hdl/l1a_fifo.sv */
`timescale 1ns/1ps
module l1a_fifo
	import ring_pkg::*;
(
	input  logic                 CLK,
	input  logic                 RST_RESYNC,
	input  l1a_rec_t             din,
	input  logic                 wr_en,
	input  logic                 rd_en,
	output l1a_rec_t             dout,
	output logic                 full,
	output logic                 empty,
	output logic [L1A_FIFO_AW:0] count
);

	l1a_rec_t mem [L1A_FIFO_DEPTH];
	logic [L1A_FIFO_AW:0] wr_ptr;
	logic [L1A_FIFO_AW:0] rd_ptr;
	logic do_wr;
	logic do_rd;

	assign do_wr = wr_en & ~full;
	assign do_rd = rd_en & ~empty;

	// extra pointer bit tells full from empty
	assign count = wr_ptr - rd_ptr;
	assign full  = (count == (L1A_FIFO_AW + 1)'(L1A_FIFO_DEPTH));
	assign empty = (count == '0);

	assign dout = mem[rd_ptr[L1A_FIFO_AW-1:0]]; // fall through

	always_ff @(posedge CLK) begin
		if (do_wr)
			mem[wr_ptr[L1A_FIFO_AW-1:0]] <= din;
	end

	always_ff @(posedge CLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	a_no_rd_empty: assert property (@(posedge CLK) disable iff (RST_RESYNC)
		rd_en |-> !empty);

	a_no_wr_full: assert property (@(posedge CLK) disable iff (RST_RESYNC)
		wr_en |-> !full);

endmodule

/* hdl/ring_pkg.sv */
package ring_pkg;

	// ring geometry
	localparam int RING_AW = 12;
	localparam int RING_DEPTH = 4096;

	// unread history above this raises warn
	localparam int WARN_LEVEL = 3328;

	localparam int L1A_FIFO_DEPTH = 16;
	localparam int L1A_FIFO_AW = $clog2(L1A_FIFO_DEPTH);

	// words needed past rd_addr before a read goes out
	localparam int RING_AMT_LEVEL = 1;

	// open window slots in the front end, also the ocnt ceiling
	localparam int OCNT_MAX = 15;

	typedef struct packed {
		logic        multi_ovlp; // more than two windows open
		logic        ovlp;       // more than one window open
		logic [3:0]  ocnt;
		logic [11:0] adc;
	} samp_word_t;

	typedef struct packed {
		logic        phase;
		logic [11:0] strt_addr; // ring address of the trigger sample
		logic [11:0] mtch_num;
		logic [23:0] l1a_num;
	} l1a_rec_t;

	// event header as sent downstream
	typedef struct packed {
		logic        phase;
		logic [11:0] mtch_num;
		logic [23:0] l1a_num;
	} evt_hdr_t;

	typedef enum logic [2:0] {
		IDLE,
		LOAD,
		READ,
		STALL,
		DONE
	} rd_state_t;

endpackage

/* hdl/ring_sample_ram.sv */
`timescale 1ns/1ps
module ring_sample_ram
	import ring_pkg::*;
(
	input  logic               CLK,
	input  logic               wea,
	input  logic [RING_AW-1:0] addra,
	input  samp_word_t         dina,
	input  logic [RING_AW-1:0] addrb,
	output samp_word_t         doutb
);

	samp_word_t mem [RING_DEPTH];

	// port a write only
	always_ff @(posedge CLK) begin
		if (wea)
			mem[addra] <= dina;
	end

	// port b registered read, old data on collision
	always_ff @(posedge CLK) begin
		doutb <= mem[addrb];
	end

endmodule

/* hdl/ring_trans_fsm.sv */
`timescale 1ns/1ps
module ring_trans_fsm
	import ring_pkg::*;
(
	input  logic       CLK,
	input  logic       RST_RESYNC,
	input  logic       l1a_buf_mt,
	input  logic       ring_amt,
	input  logic       evt_buf_afl,
	input  logic [6:0] samp_max,
	output logic       ld_addr,
	output logic       nxt_l1a,
	output logic       rd,
	output rd_state_t  evt_state
);

	rd_state_t  state;
	rd_state_t  state_nxt;
	logic [6:0] wcnt;
	logic       rd_ok;
	logic       last_wrd;

	assign rd_ok    = ~ring_amt & ~evt_buf_afl; // ring data there and room downstream
	assign last_wrd = (wcnt == samp_max - 7'd1);

	assign ld_addr   = (state == LOAD);
	assign nxt_l1a   = (state == LOAD); // pop together with the address load
	assign rd        = (state == READ) && rd_ok;
	assign evt_state = state;

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				if (!l1a_buf_mt && !evt_buf_afl)
					state_nxt = LOAD;
			end
			LOAD: begin
				if (samp_max == 7'd0)
					state_nxt = DONE; // header only
				else
					state_nxt = READ;
			end
			READ: begin
				if (!rd_ok)
					state_nxt = STALL;
				else if (last_wrd)
					state_nxt = DONE;
			end
			STALL: begin
				if (rd_ok)
					state_nxt = READ;
			end
			DONE: begin
				state_nxt = IDLE;
			end
			default: begin
				state_nxt = IDLE;
			end
		endcase
	end

	always_ff @(posedge CLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			state <= IDLE;
			wcnt  <= 7'd0;
		end else begin
			state <= state_nxt;
			if (state == LOAD)
				wcnt <= 7'd0;
			else if (rd)
				wcnt <= wcnt + 7'd1;
		end
	end

	// no read past the event length
	a_rd_len: assert property (@(posedge CLK) disable iff (RST_RESYNC)
		rd |-> (wcnt < samp_max));

endmodule

/* hdl/ringbuf.sv */
`timescale 1ns/1ps
module ringbuf
	import ring_pkg::*;
(
	input  logic       CLK,
	input  logic       RST_RESYNC,
	input  samp_word_t samp,
	input  logic       wren,
	input  l1a_rec_t   l1a_rec,
	input  logic       l1a_push,
	input  logic [6:0] samp_max,
	input  logic       evt_buf_afl,
	input  logic       evt_buf_amt,
	output logic       l1a_full,
	output evt_hdr_t   evt_hdr,
	output logic       evt_push,
	output samp_word_t rdata,
	output logic       data_push,
	output logic       warn
);

	logic [RING_AW:0]     wr_ptr;
	logic [RING_AW-1:0]   rd_addr;
	logic [RING_AW-1:0]   prev_strt_addr;
	logic [RING_AW-1:0]   oldest_strt;
	logic [RING_AW:0]     strt_ext;
	logic [RING_AW:0]     rd_ext;
	logic [RING_AW:0]     ring_cnt;
	logic [RING_AW:0]     rd_avail;
	logic                 ring_amt;
	l1a_rec_t             fifo_din;
	l1a_rec_t             fifo_dout;
	logic                 fifo_full;
	logic                 fifo_empty;
	logic [L1A_FIFO_AW:0] fifo_cnt;
	logic                 ld_addr;
	logic                 nxt_l1a;
	logic                 rd;
	rd_state_t            evt_state;
	logic                 evt_open;
	logic                 pend_vld;
	logic                 valid1;
	samp_word_t           ram_dout;
	logic [1:0]           eb_amt_sync;

	// start address is where this cycle's sample lands
	always_comb begin
		fifo_din = l1a_rec;
		fifo_din.strt_addr = wr_ptr[RING_AW-1:0];
	end

	// a push in flight takes the last free entry
	assign l1a_full = fifo_full ||
		((fifo_cnt == (L1A_FIFO_AW + 1)'(L1A_FIFO_DEPTH - 1)) && l1a_push);

	// oldest pending start is the event in readout, else the FIFO head
	assign evt_open    = evt_state inside {READ, STALL, DONE};
	assign pend_vld    = evt_open | ~fifo_empty;
	assign oldest_strt = evt_open ? prev_strt_addr : fifo_dout.strt_addr;

	// rebuild bit 12 of an address from the write pointer epoch
	assign strt_ext = {wr_ptr[RING_AW] ^ (oldest_strt > wr_ptr[RING_AW-1:0]), oldest_strt};
	assign rd_ext   = {wr_ptr[RING_AW] ^ (rd_addr > wr_ptr[RING_AW-1:0]), rd_addr};
	assign ring_cnt = wr_ptr - strt_ext;
	assign rd_avail = wr_ptr - rd_ext;

	assign ring_amt = (rd_avail <= (RING_AW + 1)'(RING_AMT_LEVEL));
	assign warn     = pend_vld && (ring_cnt > (RING_AW + 1)'(WARN_LEVEL));

	assign evt_push         = ld_addr;
	assign evt_hdr.phase    = fifo_dout.phase;
	assign evt_hdr.mtch_num = fifo_dout.mtch_num;
	assign evt_hdr.l1a_num  = fifo_dout.l1a_num;

	always_ff @(posedge CLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			wr_ptr         <= '0;
			rd_addr        <= '0;
			prev_strt_addr <= '0;
			valid1         <= 1'b0;
			data_push      <= 1'b0;
			eb_amt_sync    <= 2'b00;
		end else begin
			if (wren)
				wr_ptr <= wr_ptr + 1'b1;
			if (ld_addr)
				rd_addr <= fifo_dout.strt_addr;
			else if (rd)
				rd_addr <= rd_addr + 1'b1; // wraps with the ring
			if (nxt_l1a)
				prev_strt_addr <= fifo_dout.strt_addr;
			valid1      <= rd;     // ram read register
			data_push   <= valid1; // output register
			eb_amt_sync <= {eb_amt_sync[0], evt_buf_amt}; // status only
		end
	end

	always_ff @(posedge CLK) begin
		if (valid1)
			rdata <= ram_dout;
	end

	ring_sample_ram ring_sample_ram_i (
		.CLK   (CLK),
		.wea   (wren),
		.addra (wr_ptr[RING_AW-1:0]),
		.dina  (samp),
		.addrb (rd_addr),
		.doutb (ram_dout)
	);

	l1a_fifo l1a_fifo_i (
		.CLK        (CLK),
		.RST_RESYNC (RST_RESYNC),
		.din        (fifo_din),
		.wr_en      (l1a_push),
		.rd_en      (nxt_l1a),
		.dout       (fifo_dout),
		.full       (fifo_full),
		.empty      (fifo_empty),
		.count      (fifo_cnt)
	);

	ring_trans_fsm ring_trans_fsm_i (
		.CLK         (CLK),
		.RST_RESYNC  (RST_RESYNC),
		.l1a_buf_mt  (fifo_empty),
		.ring_amt    (ring_amt),
		.evt_buf_afl (evt_buf_afl),
		.samp_max    (samp_max),
		.ld_addr     (ld_addr),
		.nxt_l1a     (nxt_l1a),
		.rd          (rd),
		.evt_state   (evt_state)
	);

	// front end writes must never wrap onto the oldest pending start
	a_no_overrun: assert property (@(posedge CLK) disable iff (RST_RESYNC)
		wren && pend_vld |-> ring_cnt < (RING_AW + 1)'(RING_DEPTH - 1));

endmodule

/* hdl/sample_frontend.sv */
`timescale 1ns/1ps
module sample_frontend
	import ring_pkg::*;
(
	input  logic        CLK,
	input  logic        RST_RESYNC,
	input  logic [11:0] adc_data,
	input  logic        adc_valid,
	input  logic [1:0]  trig_in,
	input  logic [6:0]  samp_max,
	input  logic        l1a_full,
	output samp_word_t  samp,
	output logic        wren,
	output l1a_rec_t    l1a_rec,
	output logic        l1a_push
);

	logic        trig_v;
	logic        accept;
	logic        new_win;
	logic [6:0]  win_rem [OCNT_MAX];
	logic [4:0]  open_cnt;
	logic [3:0]  ocnt_sat;
	logic        free_vld;
	logic [3:0]  free_idx;
	logic [23:0] l1a_cnt;
	logic [11:0] mtch_cnt;

	assign trig_v  = adc_valid & trig_in[0]; // trigger without a sample is dropped
	assign accept  = trig_v & ~l1a_full;
	assign new_win = accept && (samp_max != 7'd0);

	// windows covering this sample, and a free slot for a new one
	always_comb begin
		open_cnt = {4'd0, new_win};
		free_vld = 1'b0;
		free_idx = 4'd0;
		for (int i = OCNT_MAX - 1; i >= 0; i--) begin
			if (win_rem[i] != 7'd0) begin
				open_cnt = open_cnt + 5'd1;
			end else begin
				free_vld = 1'b1;
				free_idx = 4'(i);
			end
		end
	end

	assign ocnt_sat = (open_cnt > 5'(OCNT_MAX)) ? 4'(OCNT_MAX) : open_cnt[3:0];

	always_ff @(posedge CLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			for (int i = 0; i < OCNT_MAX; i++)
				win_rem[i] <= 7'd0;
			l1a_cnt  <= 24'd0;
			mtch_cnt <= 12'd0;
			wren     <= 1'b0;
			l1a_push <= 1'b0;
		end else begin
			wren     <= adc_valid;
			l1a_push <= accept;
			if (adc_valid) begin
				for (int i = 0; i < OCNT_MAX; i++) begin
					if (new_win && free_vld && (free_idx == 4'(i)))
						win_rem[i] <= samp_max - 7'd1; // trigger sample counts as first
					else if (win_rem[i] != 7'd0)
						win_rem[i] <= win_rem[i] - 7'd1;
				end
			end
			if (trig_v)
				l1a_cnt <= l1a_cnt + 24'd1;
			if (accept)
				mtch_cnt <= mtch_cnt + 12'd1;
		end
	end

	always_ff @(posedge CLK) begin
		if (adc_valid) begin
			samp.multi_ovlp <= (open_cnt > 5'd2);
			samp.ovlp       <= (open_cnt > 5'd1);
			samp.ocnt       <= ocnt_sat;
			samp.adc        <= adc_data;
		end
		if (accept) begin
			l1a_rec.phase     <= trig_in[1];
			l1a_rec.strt_addr <= 12'd0; // filled in by the ring buffer
			l1a_rec.mtch_num  <= mtch_cnt;
			l1a_rec.l1a_num   <= l1a_cnt;
		end
	end

	// every accepted window needs a free table slot
	a_win_slot: assert property (@(posedge CLK) disable iff (RST_RESYNC)
		new_win |-> free_vld);

endmodule

/* list.f */
hdl/ring_pkg.sv
hdl/ring_sample_ram.sv
hdl/l1a_fifo.sv
hdl/ring_trans_fsm.sv
hdl/sample_frontend.sv
hdl/ringbuf.sv
hdl/daq_chan_top.sv
verification/tb_daq_chan.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
	verilator --binary --timing --assert -Wno-fatal -f list.f \
		--top-module tb_daq_chan -o sim_tb_daq_chan &&
	./obj_dir/sim_tb_daq_chan | tee /dev/stderr | grep -q "TEST RESULT: PASS" &&
	echo "simulation passed" ||
	{ echo "simulation failed"; exit 1; }

/* verification/tb_daq_chan.sv */
`timescale 1ns/1ps
module tb_daq_chan
	import ring_pkg::*;
();

	typedef struct packed {
		evt_hdr_t   hdr;
		int         start; // write index of the trigger sample
		logic [6:0] len;
	} exp_evt_t;

	logic        CLK;
	logic        RST_RESYNC;
	logic [11:0] adc_data;
	logic        adc_valid;
	logic [1:0]  trig_in;
	logic [6:0]  samp_max;
	logic        evt_buf_afl;
	logic        evt_buf_amt;
	evt_hdr_t    evt_hdr;
	logic        evt_push;
	samp_word_t  rdata;
	logic        data_push;
	logic        warn;

	samp_word_t  samp_mem [$]; // every tagged sample by write index
	int          acc_idx [$];
	int          acc_len [$];
	exp_evt_t    exp_q [$];
	exp_evt_t    cur;
	samp_word_t  exp_w;
	logic        in_evt = 1'b0;
	int          cur_cnt = 0;
	logic [23:0] l1a_cnt = 24'd0;
	logic [11:0] mtch_cnt = 12'd0;
	logic        afl_prev = 1'b0;
	int          afl_words = 0;
	int          cur_test = 0;
	int          n_checks = 0;
	int          n_hdr = 0;
	int          err [1:6] = '{default: 0};
	int          cyc = 0;
	int          cyc_limit = 20000; // twice the phase lengths and drains

	daq_chan_top daq_chan_top_i (.*);

	initial CLK = 1'b0;
	always #50 CLK = ~CLK;

	always @(posedge CLK) begin
		cyc <= cyc + 1;
		if (cyc >= cyc_limit) begin
			$display("timeout after %0d cycles, readout did not finish", cyc);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	task automatic check(input logic ok, input int slot, input string msg);
		n_checks++;
		assert (ok) else begin
			$display("error at %0t ns: %s", $time, msg);
			err[slot]++;
		end
	endtask

	// random phase covers tests 1 to 3
	function automatic int slot_for(input int base);
		return (cur_test == 1) ? base : cur_test;
	endfunction

	// one clock of stimulus plus the front end model
	task automatic step(input logic valid, input logic trig, input logic afl);
		samp_word_t  w;
		exp_evt_t    e;
		int          widx;
		int          open_n;
		logic        t;
		logic        ph;
		logic [11:0] adc;
		adc = 12'($urandom);
		ph  = 1'($urandom);
		@(posedge CLK);
		#1;
		widx   = samp_mem.size();
		open_n = 0;
		for (int i = acc_idx.size() - 1; i >= 0 && acc_idx[i] + 128 > widx; i--) begin
			if (acc_idx[i] + acc_len[i] > widx)
				open_n++;
		end
		t = trig && (open_n < OCNT_MAX - 1); // stay inside the window slots
		adc_data    = adc;
		adc_valid   = valid;
		trig_in     = {ph, t};
		evt_buf_afl = afl;
		evt_buf_amt = 1'($urandom);
		if (t && valid) begin
			// room left in the trigger FIFO, pushes in flight included
			if (exp_q.size() < L1A_FIFO_DEPTH) begin
				e.hdr.phase    = ph;
				e.hdr.mtch_num = mtch_cnt;
				e.hdr.l1a_num  = l1a_cnt;
				e.start        = widx;
				e.len          = samp_max;
				exp_q.push_back(e);
				acc_idx.push_back(widx);
				acc_len.push_back(int'(samp_max));
				open_n++;
				mtch_cnt++;
			end
			l1a_cnt++;
		end
		if (valid) begin
			w.adc        = adc;
			w.ocnt       = 4'((open_n > OCNT_MAX) ? OCNT_MAX : open_n);
			w.ovlp       = (open_n > 1);
			w.multi_ovlp = (open_n > 2);
			samp_mem.push_back(w);
		end
	endtask

	// flush the ring with quiet samples, then wait for readout to finish
	task automatic drain();
		for (int i = 0; i < 40; i++)
			step(1'b1, 1'b0, 1'b0);
		while (exp_q.size() != 0 || (in_evt && cur_cnt < int'(cur.len)))
			step(1'b0, 1'b0, 1'b0);
		repeat (4) step(1'b0, 1'b0, 1'b0);
	endtask

	task automatic report_test(input int n, input string name);
		if (err[n] == 0)
			$display("test %0d %s: ok", n, name);
		else
			$display("test %0d %s: %0d errors", n, name, err[n]);
	endtask

	always @(negedge CLK) begin
		if (!RST_RESYNC) begin
			if (evt_push) begin
				n_hdr++;
				if (in_evt)
					check(cur_cnt == int'(cur.len), slot_for(2),
						$sformatf("event %0d ended after %0d words, expected %0d",
							cur.hdr.l1a_num, cur_cnt, cur.len));
				if (exp_q.size() == 0) begin
					check(1'b0, slot_for(1), "header arrived with no trigger left to match it");
					in_evt = 1'b0;
				end else begin
					cur     = exp_q.pop_front();
					in_evt  = 1'b1;
					cur_cnt = 0;
					check(evt_hdr == cur.hdr, slot_for(1),
						$sformatf("header %h, expected %h", evt_hdr, cur.hdr));
				end
			end
			if (data_push) begin
				if (!in_evt || cur_cnt >= int'(cur.len)) begin
					check(1'b0, slot_for(2), "data word arrived outside any event");
				end else begin
					exp_w = samp_mem[cur.start + cur_cnt];
					check(rdata.adc == exp_w.adc, slot_for(2),
						$sformatf("word %0d adc %h, expected %h", cur_cnt, rdata.adc, exp_w.adc));
					check(rdata[17:12] == exp_w[17:12], slot_for(3),
						$sformatf("word %0d tag %h, expected %h", cur_cnt,
							rdata[17:12], exp_w[17:12]));
					cur_cnt++;
				end
			end
			if (evt_buf_afl && !afl_prev)
				afl_words = 0;
			if (evt_buf_afl && data_push) begin
				afl_words++;
				check(afl_words <= 2, 4,
					$sformatf("%0d data words after almost full", afl_words));
			end
			afl_prev = evt_buf_afl;
		end
	end

	initial begin
		int h0;
		int total;
		void'($urandom(92800));
		RST_RESYNC  = 1'b1;
		adc_data    = 12'd0;
		adc_valid   = 1'b0;
		trig_in     = 2'b00;
		samp_max    = 7'd16;
		evt_buf_afl = 1'b0;
		evt_buf_amt = 1'b0;
		repeat (3) @(posedge CLK);
		#1;
		RST_RESYNC = 1'b0;
		check(!warn, 6, "warn high after reset");

		cur_test = 1;
		samp_max = 7'(4 + $urandom % 21);
		for (int i = 0; i < 1500; i++)
			step($urandom % 4 != 0, $urandom % 16 == 0, 1'b0);
		drain();
		report_test(1, "headers");
		report_test(2, "event data");
		report_test(3, "overlap tags");

		cur_test = 4;
		samp_max = 7'(4 + $urandom % 21);
		for (int i = 0; i < 1500; i++)
			step($urandom % 4 != 0, $urandom % 16 == 0, $urandom % 3 == 0);
		drain();
		report_test(4, "back-pressure");

		cur_test = 5;
		samp_max = 7'd1;
		step(1'b0, 1'b0, 1'b1);
		h0 = n_hdr;
		for (int i = 0; i < 40; i++)
			step(1'b1, 1'b1, 1'b1); // burst with readout held
		drain();
		check(n_hdr - h0 == L1A_FIFO_DEPTH, 5,
			$sformatf("%0d events read out after a burst of 40", n_hdr - h0));
		report_test(5, "trigger FIFO full");

		cur_test = 6;
		samp_max = 7'd8;
		step(1'b0, 1'b0, 1'b1);
		step(1'b1, 1'b1, 1'b1);
		for (int i = 0; i < 3000; i++)
			step(1'b1, 1'b0, 1'b1);
		check(!warn, 6, "warn high below the warning level");
		for (int i = 0; i < 400; i++)
			step(1'b1, 1'b0, 1'b1);
		check(warn, 6, "warn low with the backlog over the warning level");
		drain();
		check(!warn, 6, "warn still high after the backlog drained");
		report_test(6, "warning");

		total = 0;
		for (int i = 1; i <= 6; i++)
			total += err[i];
		$display("checks %0d, errors %0d", n_checks, total);
		if (total == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule
